/* common/dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // address and data geometry
    parameter int addr_w         = 32;
    parameter int word_w         = 32;
    parameter int words_per_line = 4;
    parameter int offset_w       = 4;
    parameter int line_w         = word_w * words_per_line;
    parameter int strb_w         = word_w / 8;

    // associativity
    parameter int num_ways = 2;

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_dirty_wb,
        st_replace,
        st_refill,
        st_respond
    } cache_state_e;

    // cpu request opcode
    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } req_op_e;

endpackage

`default_nettype wire

/* dcache/data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module data_array #(
    parameter int index_w = 8
) (
    input  logic                          clk,
    input  logic [index_w-1:0]            look_index,
    input  logic                          data_we_way,
    input  logic [1:0]                    data_we_word,
    input  logic [dcache_pkg::strb_w-1:0] data_we_strb,
    input  logic [dcache_pkg::word_w-1:0] data_wdata,
    input  logic                          data_rd_way,
    output logic [dcache_pkg::line_w-1:0] line_rdata
);

    import dcache_pkg::*;

    localparam int sets = 1 << index_w;

    // one word bank per way and word position
    logic [word_w-1:0] bank_q [num_ways][words_per_line][sets];

    // byte-lane writes into the addressed bank
    always_ff @(posedge clk)
    begin
        for (int b = 0; b < strb_w; b++)
        begin
            if (data_we_strb[b])
                bank_q[data_we_way][data_we_word][look_index][8*b +: 8]
                    <= data_wdata[8*b +: 8];
        end
    end

    // whole line of the selected way, word 0 in the low bits
    always_comb
    begin
        for (int w = 0; w < words_per_line; w++)
        begin
            line_rdata[w*word_w +: word_w] = bank_q[data_rd_way][w][look_index];
        end
    end

endmodule

`default_nettype wire

/* dcache/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter int index_w = 8,
    localparam int tag_w = dcache_pkg::addr_w - index_w - dcache_pkg::offset_w
) (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              valid,
    input  logic                              op,
    input  logic [index_w-1:0]                index,
    input  logic [tag_w-1:0]                  tag,
    input  logic [dcache_pkg::offset_w-1:0]   offset,
    input  logic [dcache_pkg::strb_w-1:0]     wstrb,
    input  logic [dcache_pkg::word_w-1:0]     wdata,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [dcache_pkg::word_w-1:0]     rdata,
    output logic                              rd_req,
    output logic [dcache_pkg::addr_w-1:0]     rd_addr,
    input  logic                              rd_rdy,
    input  logic                              ret_valid,
    input  logic                              ret_last,
    input  logic [dcache_pkg::word_w-1:0]     ret_data,
    output logic                              wr_req,
    output logic [dcache_pkg::addr_w-1:0]     wr_addr,
    output logic [dcache_pkg::line_w-1:0]     wr_data,
    input  logic                              wr_rdy,
    output logic [index_w-1:0]                look_index,
    output logic [tag_w-1:0]                  look_tag,
    input  logic                              hit,
    input  logic                              hit_way,
    input  logic [dcache_pkg::num_ways-1:0]   way_valid,
    input  logic [dcache_pkg::num_ways-1:0]   way_dirty,
    input  logic [tag_w-1:0]                  way_tag0,
    input  logic [tag_w-1:0]                  way_tag1,
    output logic                              tag_we,
    output logic                              tag_we_way,
    output logic                              tag_dirty_in,
    output logic                              dirty_set,
    output logic                              data_we_way,
    output logic [1:0]                        data_we_word,
    output logic [dcache_pkg::strb_w-1:0]     data_we_strb,
    output logic [dcache_pkg::word_w-1:0]     data_wdata,
    output logic                              data_rd_way,
    input  logic [dcache_pkg::line_w-1:0]     line_rdata
);

    import dcache_pkg::*;

    cache_state_e       state;
    cache_state_e       state_nxt;
    req_op_e            buf_op;
    logic [index_w-1:0] buf_index;
    logic [tag_w-1:0]   buf_tag;
    logic [1:0]         buf_word;
    logic [strb_w-1:0]  buf_wstrb;
    logic [word_w-1:0]  buf_wdata;
    logic               buf_way;
    logic [15:0]        lfsr;
    logic [1:0]         refill_cnt;
    logic               victim_way;
    logic               victim_dirty;
    logic [tag_w-1:0]   victim_tag;
    logic [word_w-1:0]  refill_word;

    assign addr_ok = valid && (state == st_idle);

    // request buffer, loaded on accept
    always_ff @(posedge clk)
    begin
        if (addr_ok)
        begin
            buf_op    <= req_op_e'(op);
            buf_index <= index;
            buf_tag   <= tag;
            buf_word  <= offset[offset_w-1:2];
            buf_wstrb <= wstrb;
            buf_wdata <= wdata;
        end
    end

    // invalid way first, else a pseudo-random pick
    assign victim_way   = !way_valid[0] ? 1'b0 : (!way_valid[1] ? 1'b1 : lfsr[0]);
    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];
    assign victim_tag   = buf_way ? way_tag1 : way_tag0;

    always_ff @(posedge clk)
    begin
        if (state == st_lookup)
            buf_way <= hit ? hit_way : victim_way;
    end

    // galois lfsr, taps 16,14,13,11
    always_ff @(posedge clk)
    begin
        if (!resetn)
            lfsr <= 16'hace1;
        else
            lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hb400 : 16'h0000);
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:     if (valid) state_nxt = st_lookup;
            st_lookup:
            begin
                if (hit)
                    state_nxt = st_idle;
                else if (victim_dirty)
                    state_nxt = st_dirty_wb;
                else
                    state_nxt = st_replace;
            end
            st_dirty_wb: if (wr_rdy) state_nxt = st_replace;
            st_replace:  if (rd_rdy) state_nxt = st_refill;
            st_refill:   if (ret_valid && ret_last) state_nxt = st_respond;
            default:     state_nxt = st_idle;
        endcase
    end

    // beat counter, wraps back to 0 after the fourth beat
    always_ff @(posedge clk)
    begin
        if (!resetn)
            refill_cnt <= 2'd0;
        else if (state == st_refill && ret_valid)
            refill_cnt <= refill_cnt + 2'd1;
    end

    // merge buffered store bytes into the matching beat
    always_comb
    begin
        refill_word = ret_data;
        if (buf_op == op_store && refill_cnt == buf_word)
        begin
            for (int b = 0; b < strb_w; b++)
            begin
                if (buf_wstrb[b])
                    refill_word[8*b +: 8] = buf_wdata[8*b +: 8];
            end
        end
    end

    assign look_index = buf_index;
    assign look_tag   = buf_tag;

    // tag written with the last beat; dirty only for a store
    assign tag_we       = (state == st_refill) && ret_valid && ret_last;
    assign tag_we_way   = (state == st_lookup) ? hit_way : buf_way;
    assign tag_dirty_in = (buf_op == op_store);
    assign dirty_set    = (state == st_lookup) && hit && (buf_op == op_store);

    always_comb
    begin
        data_we_way  = buf_way;
        data_we_word = refill_cnt;
        data_we_strb = '0;
        data_wdata   = refill_word;
        if (state == st_lookup)
        begin
            data_we_way  = hit_way;
            data_we_word = buf_word;
            data_wdata   = buf_wdata;
            if (hit && buf_op == op_store)
                data_we_strb = buf_wstrb;
        end
        else if (state == st_refill && ret_valid)
            data_we_strb = '1;
    end

    assign data_rd_way = (state == st_lookup) ? hit_way : buf_way;

    assign data_ok = ((state == st_lookup) && hit) || (state == st_respond);
    assign rdata   = line_rdata[buf_word*word_w +: word_w];

    // line-aligned memory requests
    assign rd_req  = (state == st_replace);
    assign rd_addr = {buf_tag, buf_index, {offset_w{1'b0}}};
    assign wr_req  = (state == st_dirty_wb);
    assign wr_addr = {victim_tag, buf_index, {offset_w{1'b0}}};
    assign wr_data = line_rdata;

endmodule

`default_nettype wire

/* dcache/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int index_w = 8,
    localparam int tag_w = dcache_pkg::addr_w - index_w - dcache_pkg::offset_w
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            valid,
    input  logic                            op,
    input  logic [index_w-1:0]              index,
    input  logic [tag_w-1:0]                tag,
    input  logic [dcache_pkg::offset_w-1:0] offset,
    input  logic [dcache_pkg::strb_w-1:0]   wstrb,
    input  logic [dcache_pkg::word_w-1:0]   wdata,
    output logic                            addr_ok,
    output logic                            data_ok,
    output logic [dcache_pkg::word_w-1:0]   rdata,
    output logic                            rd_req,
    output logic [dcache_pkg::addr_w-1:0]   rd_addr,
    input  logic                            rd_rdy,
    input  logic                            ret_valid,
    input  logic                            ret_last,
    input  logic [dcache_pkg::word_w-1:0]   ret_data,
    output logic                            wr_req,
    output logic [dcache_pkg::addr_w-1:0]   wr_addr,
    output logic [dcache_pkg::line_w-1:0]   wr_data,
    input  logic                            wr_rdy
);

    import dcache_pkg::*;

    // lookup address shared by both stores
    logic [index_w-1:0]  look_index;
    logic [tag_w-1:0]    look_tag;

    // tag store results
    logic                hit;
    logic                hit_way;
    logic [num_ways-1:0] way_valid;
    logic [num_ways-1:0] way_dirty;
    logic [tag_w-1:0]    way_tag0;
    logic [tag_w-1:0]    way_tag1;

    // tag store updates
    logic                tag_we;
    logic                tag_we_way;
    logic                tag_dirty_in;
    logic                dirty_set;

    // data store access
    logic                data_we_way;
    logic [1:0]          data_we_word;
    logic [strb_w-1:0]   data_we_strb;
    logic [word_w-1:0]   data_wdata;
    logic                data_rd_way;
    logic [line_w-1:0]   line_rdata;

    dcache_ctrl #(.index_w(index_w)) u_ctrl (.*);

    tag_array #(.index_w(index_w)) u_tag_array (.*);

    data_array #(.index_w(index_w)) u_data_array (.*);

endmodule

`default_nettype wire

/* dcache/tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_array #(
    parameter int index_w = 8,
    localparam int tag_w = dcache_pkg::addr_w - index_w - dcache_pkg::offset_w
) (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic [index_w-1:0]              look_index,
    input  logic [tag_w-1:0]                look_tag,
    output logic                            hit,
    output logic                            hit_way,
    output logic [dcache_pkg::num_ways-1:0] way_valid,
    output logic [dcache_pkg::num_ways-1:0] way_dirty,
    output logic [tag_w-1:0]                way_tag0,
    output logic [tag_w-1:0]                way_tag1,
    input  logic                            tag_we,
    input  logic                            tag_we_way,
    input  logic                            tag_dirty_in,
    input  logic                            dirty_set
);

    import dcache_pkg::*;

    localparam int sets = 1 << index_w;

    logic [sets-1:0]  valid_q [num_ways];
    logic [sets-1:0]  dirty_q [num_ways];
    logic [tag_w-1:0] tag_q   [num_ways][sets];
    logic [num_ways-1:0] way_hit;

    // valid and dirty bits, cleared by reset
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            for (int w = 0; w < num_ways; w++)
            begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end
        else if (tag_we)
        begin
            valid_q[tag_we_way][look_index] <= 1'b1;
            dirty_q[tag_we_way][look_index] <= tag_dirty_in;
        end
        else if (dirty_set)
            dirty_q[tag_we_way][look_index] <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (tag_we)
            tag_q[tag_we_way][look_index] <= look_tag;
    end

    always_comb
    begin
        for (int w = 0; w < num_ways; w++)
        begin
            way_valid[w] = valid_q[w][look_index];
            way_dirty[w] = dirty_q[w][look_index];
            way_hit[w]   = way_valid[w] && (tag_q[w][look_index] == look_tag);
        end
    end

    assign way_tag0 = tag_q[0][look_index];
    assign way_tag1 = tag_q[1][look_index];
    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];

endmodule

`default_nettype wire

/* files.f */
common/dcache_pkg.sv
dcache/tag_array.sv
dcache/data_array.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
sim/dcache_assertions.sv
sim/tb_dcache.sv

/* sim/dcache_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
    input logic                          clk,
    input logic                          resetn,
    input logic                          valid,
    input logic                          addr_ok,
    input logic                          data_ok,
    input logic                          rd_req,
    input logic [dcache_pkg::addr_w-1:0] rd_addr,
    input logic                          rd_rdy,
    input logic                          wr_req,
    input logic [dcache_pkg::addr_w-1:0] wr_addr,
    input logic                          wr_rdy
);

    int   assert_errors = 0;
    logic pending;

    // accepted request still waiting for its data_ok
    always_ff @(posedge clk)
    begin
        if (!resetn)
            pending <= 1'b0;
        else if (data_ok)
            pending <= 1'b0;
        else if (valid && addr_ok)
            pending <= 1'b1;
    end

    rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
    else
    begin
        assert_errors++;
        $error("rd_req dropped or rd_addr changed before rd_rdy");
    end

    wr_hold: assert property (@(posedge clk) disable iff (!resetn)
        wr_req && !wr_rdy |=> wr_req && $stable(wr_addr))
    else
    begin
        assert_errors++;
        $error("wr_req dropped or wr_addr changed before wr_rdy");
    end

    no_overlap: assert property (@(posedge clk) disable iff (!resetn)
        pending |-> !addr_ok)
    else
    begin
        assert_errors++;
        $error("addr_ok raised while a request was outstanding");
    end

    reset_quiet: assert property (@(posedge clk)
        !resetn |=> !data_ok && !rd_req && !wr_req)
    else
    begin
        assert_errors++;
        $error("data_ok, rd_req or wr_req high after reset");
    end

endmodule

`default_nettype wire

/* sim/tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    import dcache_pkg::*;

    localparam int     num_requests = 2000;
    localparam int     index_w      = 8;
    localparam int     tag_w        = addr_w - index_w - offset_w;
    localparam longint timeout_ns   = longint'(num_requests) * 60 * 20;

    logic clk = 1'b0;
    logic resetn;
    logic valid;
    logic op;
    logic [index_w-1:0]  index;
    logic [tag_w-1:0]    tag;
    logic [offset_w-1:0] offset;
    logic [strb_w-1:0]   wstrb;
    logic [word_w-1:0]   wdata;
    logic addr_ok;
    logic data_ok;
    logic [word_w-1:0]   rdata;
    logic rd_req;
    logic [addr_w-1:0]   rd_addr;
    logic rd_rdy;
    logic ret_valid;
    logic ret_last;
    logic [word_w-1:0]   ret_data;
    logic wr_req;
    logic [addr_w-1:0]   wr_addr;
    logic [line_w-1:0]   wr_data;
    logic wr_rdy;

    // outputs captured at the rising edge, read back at the falling edge
    logic acc_q = 1'b0;
    logic dok_q = 1'b0;
    logic memreq_q = 1'b0;
    logic [word_w-1:0] rdata_q;

    // backing memory and the expected view, keyed by word address
    logic [word_w-1:0] mem_q    [logic [addr_w-3:0]];
    logic [word_w-1:0] shadow_q [logic [addr_w-3:0]];
    logic [31:0]       lfsr_q = 32'hc41c_7a59;

    dcache_top #(.index_w(index_w)) uut (.*);

    bind dcache_top dcache_assertions u_assert (.*);

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        acc_q    <= valid && addr_ok;
        dok_q    <= data_ok;
        rdata_q  <= rdata;
        memreq_q <= rd_req || wr_req;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            b      = lfsr_q[0];
            lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
            r      = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic [word_w-1:0] fill_word(input logic [addr_w-1:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [word_w-1:0] mem_word(input logic [addr_w-1:0] a);
        if (mem_q.exists(a[addr_w-1:2]))
            return mem_q[a[addr_w-1:2]];
        return fill_word({a[addr_w-1:2], 2'b00});
    endfunction

    function automatic logic [word_w-1:0] shadow_word(input logic [addr_w-1:0] a);
        if (shadow_q.exists(a[addr_w-1:2]))
            return shadow_q[a[addr_w-1:2]];
        return fill_word({a[addr_w-1:2], 2'b00});
    endfunction

    function automatic logic [line_w-1:0] shadow_line(input logic [addr_w-1:0] a);
        logic [line_w-1:0] l;
        for (int w = 0; w < words_per_line; w++)
            l[w*word_w +: word_w] = shadow_word({a[addr_w-1:offset_w], 2'(w), 2'b00});
        return l;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string check_name, input logic [line_w-1:0] expected,
                                   input logic [line_w-1:0] actual);
        stop_with_failure($sformatf("error: %s expected %0h actual %0h",
                                    check_name, expected, actual));
    endtask

    // victim line goes to memory after a random delay
    task automatic serve_write();
        logic [line_w-1:0] expected;
        repeat (rand_bits(2)) @(negedge clk);
        expected = shadow_line(wr_addr);
        assert (wr_data == expected)
        else report_mismatch("writeback_line", expected, wr_data);
        for (int w = 0; w < words_per_line; w++)
            mem_q[{wr_addr[addr_w-1:offset_w], 2'(w)}] = wr_data[w*word_w +: word_w];
        wr_rdy = 1'b1;
        @(negedge clk);
        wr_rdy = 1'b0;
    endtask

    // four beats in word order, with random gaps
    task automatic serve_read();
        logic [addr_w-1:0] line_addr;
        repeat (rand_bits(2)) @(negedge clk);
        line_addr = rd_addr;
        rd_rdy    = 1'b1;
        @(negedge clk);
        rd_rdy = 1'b0;
        for (int beat = 0; beat < words_per_line; beat++)
        begin
            repeat (rand_bits(2)) @(negedge clk);
            ret_valid = 1'b1;
            ret_last  = (beat == words_per_line - 1);
            ret_data  = mem_word(line_addr + 32'(4 * beat));
            @(negedge clk);
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
    endtask

    task automatic run_request(input logic [addr_w-1:0] addr, input logic is_store,
                               input logic [strb_w-1:0] strb, input logic [word_w-1:0] data,
                               input logic same_line);
        logic [word_w-1:0] expected;
        int                latency;
        logic              mem_seen;
        valid  = 1'b1;
        op     = is_store;
        tag    = addr[addr_w-1 -: tag_w];
        index  = addr[offset_w +: index_w];
        offset = addr[offset_w-1:0];
        wstrb  = strb;
        wdata  = data;
        do
        begin
            @(negedge clk);
        end
        while (!acc_q);
        expected = shadow_word(addr);
        if (is_store)
        begin
            for (int b = 0; b < strb_w; b++)
            begin
                if (strb[b])
                    expected[8*b +: 8] = data[8*b +: 8];
            end
            shadow_q[addr[addr_w-1:2]] = expected;
        end
        latency  = 0;
        mem_seen = 1'b0;
        do
        begin
            @(negedge clk);
            latency++;
            mem_seen = mem_seen | memreq_q;
        end
        while (!dok_q);
        // cpu keeps valid up until data_ok
        valid = 1'b0;
        if (!is_store)
        begin
            assert (rdata_q == expected)
            else report_mismatch("load_data", expected, rdata_q);
        end
        if (same_line)
        begin
            assert (latency == 1)
            else report_mismatch("hit_latency", 1, latency);
            assert (!mem_seen)
            else stop_with_failure("memory request seen during a repeated-line hit");
        end
    endtask

    // memory model
    initial
    begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        wait (resetn === 1'b1);
        forever
        begin
            @(negedge clk);
            if (wr_req)
                serve_write();
            else if (rd_req)
                serve_read();
        end
    end

    always @(negedge clk)
    begin
        if (uut.u_assert.assert_errors != 0)
            stop_with_failure("a bound handshake or reset assertion failed");
    end

    initial
    begin
        #(timeout_ns);
        stop_with_failure("watchdog expired before all requests completed");
    end

    initial
    begin
        logic [addr_w-1:0] addr;
        logic [addr_w-1:0] prev_addr;
        logic [1:0]        tag_sel;
        logic              set_sel;
        logic [1:0]        word_sel;
        valid     = 1'b0;
        op        = 1'b0;
        index     = '0;
        tag       = '0;
        offset    = '0;
        wstrb     = '0;
        wdata     = '0;
        resetn    = 1'b0;
        prev_addr = '1;
        repeat (10) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        for (int n = 0; n < num_requests; n++)
        begin
            // two sets and four tags keep both ways busy
            tag_sel  = 2'(rand_bits(2));
            set_sel  = rand_bits(1) != 0;
            word_sel = 2'(rand_bits(2));
            addr     = {tag_sel, 18'h2b4d1, (set_sel ? 8'ha5 : 8'h3c), word_sel, 2'b00};
            if (n % 5 == 4)
                addr[addr_w-1:offset_w] = prev_addr[addr_w-1:offset_w];
            run_request(addr, rand_bits(1) != 0, strb_w'(rand_bits(4)), rand_bits(32),
                        addr[addr_w-1:offset_w] == prev_addr[addr_w-1:offset_w]);
            prev_addr = addr;
        end
        if (uut.u_assert.assert_errors != 0)
            stop_with_failure("a bound handshake or reset assertion failed");
        else
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
